// ==== Bender.yml ====
package:
  name: rv32i_single_cycle

export_include_dirs:
  - include

sources:
  - files:
      - design/cpu_pkg.sv
      - design/control_unit.sv
      - design/pc_unit.sv
      - design/instr_mem.sv
      - design/reg_alu.sv
      - design/data_mem.sv
      - design/cpu_top.sv
  - target: test
    files:
      - tests/cpu_model.sv
      - tests/tb_cpu.sv

// ==== design/control_unit.sv ====
`include "cpu_defs.svh"

module control_unit (
    input  logic [`CPU_XLEN-1:0] instr_i,
    output cpu_pkg::ctrl_t       ctrl_o
);
    import cpu_pkg::*;

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_s;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_j;
    logic [`CPU_XLEN-1:0] imm_u;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};

    always_comb begin
        // No-op unless a legal encoding matches below
        ctrl_o             = '0;
        ctrl_o.alu_op      = ALU_ADD;
        ctrl_o.wb_sel      = ALU;
        ctrl_o.rs1         = instr_i[19:15];
        ctrl_o.rs2         = instr_i[24:20];
        ctrl_o.rd          = instr_i[11:7];

        case (opcode)
            OP: begin
                ctrl_o.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl_o.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl_o.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl_o.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl_o.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl_o.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl_o.alu_op = ALU_SLT;
                    default:              ctrl_o.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl_o.imm         = imm_i;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = (funct3 == 3'b000); // ADDI only
            end
            LUI: begin
                ctrl_o.imm         = imm_u;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = ALU_PASS_B;
                ctrl_o.reg_write   = 1'b1;
            end
            LOAD: begin
                ctrl_o.imm         = imm_i;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.wb_sel      = MEM;
                ctrl_o.reg_write   = (funct3 == 3'b010); // LW only
            end
            STORE: begin
                ctrl_o.imm         = imm_s;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = (funct3 == 3'b010); // SW only
            end
            BRANCH: begin
                ctrl_o.imm       = imm_b;
                ctrl_o.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl_o.branch_ne = (funct3 == 3'b001);
            end
            JAL: begin
                ctrl_o.imm       = imm_j;
                ctrl_o.jump      = 1'b1;
                ctrl_o.wb_sel    = PC_PLUS4;
                ctrl_o.reg_write = 1'b1;
            end
            JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl_o.imm         = imm_i;
                    ctrl_o.alu_src_imm = 1'b1; // Target is rs1 plus imm
                    ctrl_o.jalr        = 1'b1;
                    ctrl_o.wb_sel      = PC_PLUS4;
                    ctrl_o.reg_write   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // A store never writes back, whatever the opcode decode path
    always_comb begin
        assert final (!(ctrl_o.reg_write && ctrl_o.mem_write))
            else $error("reg_write and mem_write both set");
    end

endmodule

// ==== design/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6 // LUI passes the immediate through
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU      = 2'd0,
        MEM      = 2'd1,
        PC_PLUS4 = 2'd2 // Link value for JAL and JALR
    } wb_sel_e;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_write;
        logic                   alu_src_imm; // Operand B from imm, not rs2
        logic                   branch;
        logic                   branch_ne;   // BNE rather than BEQ
        logic                   jump;
        logic                   jalr;
        alu_op_e                alu_op;
        wb_sel_e                wb_sel;
        logic [`CPU_REG_AW-1:0] rs1;
        logic [`CPU_REG_AW-1:0] rs2;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   imm;
    } ctrl_t;

    // One record per retired instruction
    typedef struct packed {
        logic                   valid;
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_XLEN-1:0]   instr;
        logic                   reg_write;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_XLEN-1:0]   wdata;
        logic                   mem_write;
        logic [`CPU_XLEN-1:0]   mem_addr;
        logic [`CPU_XLEN-1:0]   mem_wdata;
    } retire_t;

endpackage

// ==== design/cpu_top.sv ====
`include "cpu_defs.svh"

module cpu_top (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    prog_we_i,
    input  logic [`CPU_IMEM_AW-1:0] prog_addr_i,
    input  logic [`CPU_XLEN-1:0]    prog_data_i,
    output cpu_pkg::retire_t        retire_o,
    output logic [`CPU_XLEN-1:0]    a0_o
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] instr;
    ctrl_t                ctrl;
    logic [`CPU_XLEN-1:0] alu_out;
    logic [`CPU_XLEN-1:0] rs2_val;
    logic                 take_branch;
    logic [`CPU_XLEN-1:0] wb_data;
    logic [`CPU_XLEN-1:0] mem_rdata;
    logic                 mem_write;
    logic                 reg_write;

    assign reg_write = ctrl.reg_write && !reset_i;
    assign mem_write = ctrl.mem_write && !reset_i;

    pc_unit u_pc_unit (
        .clk_i         ( clk_i ),
        .reset_i       ( reset_i ),
        .ctrl_i        ( ctrl ),
        .take_branch_i ( take_branch ),
        .alu_out_i     ( alu_out ),
        .pc_o          ( pc )
    );

    instr_mem u_instr_mem (
        .clk_i       ( clk_i ),
        .prog_we_i   ( prog_we_i ),
        .prog_addr_i ( prog_addr_i ),
        .prog_data_i ( prog_data_i ),
        .pc_i        ( pc ),
        .instr_o     ( instr )
    );

    control_unit u_control_unit (
        .instr_i ( instr ),
        .ctrl_o  ( ctrl )
    );

    reg_alu u_reg_alu (
        .clk_i         ( clk_i ),
        .reset_i       ( reset_i ),
        .ctrl_i        ( ctrl ),
        .pc_i          ( pc ),
        .mem_rdata_i   ( mem_rdata ),
        .alu_out_o     ( alu_out ),
        .rs2_val_o     ( rs2_val ),
        .take_branch_o ( take_branch ),
        .wb_data_o     ( wb_data ),
        .a0_o          ( a0_o )
    );

    data_mem u_data_mem (
        .clk_i   ( clk_i ),
        .reset_i ( reset_i ),
        .we_i    ( mem_write ),
        .addr_i  ( alu_out ),
        .wdata_i ( rs2_val ),
        .rdata_o ( mem_rdata )
    );

    // Retire record, with write fields zeroed when no write happens
    assign retire_o.valid     = !reset_i;
    assign retire_o.pc        = pc;
    assign retire_o.instr     = instr;
    assign retire_o.reg_write = reg_write;
    assign retire_o.rd        = reg_write ? ctrl.rd : '0;
    assign retire_o.wdata     = reg_write ? wb_data : '0;
    assign retire_o.mem_write = mem_write;
    assign retire_o.mem_addr  = mem_write ? alu_out : '0;
    assign retire_o.mem_wdata = mem_write ? rs2_val : '0;

endmodule

// ==== design/data_mem.sv ====
`include "cpu_defs.svh"

module data_mem (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  logic [`CPU_XLEN-1:0] addr_i,  // Byte address
    input  logic [`CPU_XLEN-1:0] wdata_i,
    output logic [`CPU_XLEN-1:0] rdata_o
);

    logic [`CPU_XLEN-1:0]    mem [`CPU_DMEM_WORDS];
    logic [`CPU_DMEM_AW-1:0] word_idx;

    // Low two bits dropped, upper bits wrap at the depth
    assign word_idx = addr_i[`CPU_DMEM_AW+1:2];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[word_idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[word_idx]; // Same-cycle read for LW

endmodule

// ==== design/instr_mem.sv ====
`include "cpu_defs.svh"

module instr_mem (
    input  logic                    clk_i,
    input  logic                    prog_we_i,
    input  logic [`CPU_IMEM_AW-1:0] prog_addr_i, // Word index
    input  logic [`CPU_XLEN-1:0]    prog_data_i,
    input  logic [`CPU_XLEN-1:0]    pc_i,
    output logic [`CPU_XLEN-1:0]    instr_o
);

    logic [`CPU_XLEN-1:0]    mem [`CPU_IMEM_WORDS];
    logic [`CPU_IMEM_AW-1:0] fetch_idx;

    // Program port loads words at any time, reset or not
    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            mem[prog_addr_i] <= prog_data_i;
        end
    end

    // Byte address to word index, wrapping at the depth
    assign fetch_idx = pc_i[`CPU_IMEM_AW+1:2];
    assign instr_o   = mem[fetch_idx];

endmodule

// ==== design/pc_unit.sv ====
`include "cpu_defs.svh"

module pc_unit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  cpu_pkg::ctrl_t       ctrl_i,
    input  logic                 take_branch_i,
    input  logic [`CPU_XLEN-1:0] alu_out_i,
    output logic [`CPU_XLEN-1:0] pc_o
);
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] pc_q;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] pc_target;
    logic [`CPU_XLEN-1:0] pc_next;

    assign pc_plus4  = pc_q + `CPU_XLEN'd4;
    assign pc_target = pc_q + ctrl_i.imm; // JAL and taken branches

    always_comb begin
        if (ctrl_i.jalr) begin
            pc_next = {alu_out_i[`CPU_XLEN-1:2], 2'b00}; // Word aligned jump
        end else if (ctrl_i.jump || take_branch_i) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `CPU_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // Fetch must stay word aligned across all jumps and branches
    pc_aligned_a: assert property (@(posedge clk_i) disable iff (reset_i)
        pc_q[1:0] == 2'b00)
        else $error("PC misaligned: %h", pc_q);

endmodule

// ==== design/reg_alu.sv ====
`include "cpu_defs.svh"

module reg_alu (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  cpu_pkg::ctrl_t       ctrl_i,
    input  logic [`CPU_XLEN-1:0] pc_i,
    input  logic [`CPU_XLEN-1:0] mem_rdata_i,
    output logic [`CPU_XLEN-1:0] alu_out_o,
    output logic [`CPU_XLEN-1:0] rs2_val_o,
    output logic                 take_branch_o,
    output logic [`CPU_XLEN-1:0] wb_data_o,
    output logic [`CPU_XLEN-1:0] a0_o
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 1 << `CPU_REG_AW;

    logic [`CPU_XLEN-1:0] regs [NUM_REGS];
    logic [`CPU_XLEN-1:0] rs1_val;
    logic [`CPU_XLEN-1:0] rs2_val;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_out;
    logic                 rs_eq;

    // Two combinational read ports
    assign rs1_val = regs[ctrl_i.rs1];
    assign rs2_val = regs[ctrl_i.rs2];

    assign op_b = ctrl_i.alu_src_imm ? ctrl_i.imm : rs2_val;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:    alu_out = rs1_val + op_b;
            ALU_SUB:    alu_out = rs1_val - op_b;
            ALU_AND:    alu_out = rs1_val & op_b;
            ALU_OR:     alu_out = rs1_val | op_b;
            ALU_XOR:    alu_out = rs1_val ^ op_b;
            ALU_SLT:    alu_out = {{(`CPU_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = rs1_val + op_b;
        endcase
    end

    // BEQ and BNE share one comparator
    assign rs_eq         = (rs1_val == rs2_val);
    assign take_branch_o = ctrl_i.branch && (ctrl_i.branch_ne ? !rs_eq : rs_eq);

    always_comb begin
        case (ctrl_i.wb_sel)
            ALU:      wb_data_o = alu_out;
            MEM:      wb_data_o = mem_rdata_i;
            PC_PLUS4: wb_data_o = pc_i + `CPU_XLEN'd4;
            default:  wb_data_o = alu_out;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.reg_write && (ctrl_i.rd != '0)) begin // x0 never written
            regs[ctrl_i.rd] <= wb_data_o;
        end
    end

    assign alu_out_o = alu_out;
    assign rs2_val_o = rs2_val; // Store data
    assign a0_o      = regs[10];

    // Entry 0 keeps its reset value for the whole run
    x0_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
        regs[0] == '0)
        else $error("x0 holds %h", regs[0]);

endmodule

// ==== include/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and address width
`define CPU_XLEN 32

// Register file address width
`define CPU_REG_AW 5

// Instruction memory geometry, in words
`define CPU_IMEM_WORDS 64
`define CPU_IMEM_AW 6

// Data memory geometry, in words
`define CPU_DMEM_WORDS 32
`define CPU_DMEM_AW 5

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== list.f ====
+incdir+include
design/cpu_pkg.sv
design/control_unit.sv
design/pc_unit.sv
design/instr_mem.sv
design/reg_alu.sv
design/data_mem.sv
design/cpu_top.sv
tests/cpu_model.sv
tests/tb_cpu.sv

// ==== tests/cpu_model.sv ====
`include "cpu_defs.svh"

module cpu_model;
    import cpu_pkg::*;

    logic [`CPU_XLEN-1:0] regs [32];
    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] next_pc;
    retire_t              exp_ret; // Expected record for the instruction at pc

    // Random word from the subset, plus an occasional unknown encoding
    function automatic logic [31:0] make_instr(input logic [31:0] r1, input logic [31:0] r2);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] mimm;
        logic [12:0] bofs;
        logic [20:0] jofs;
        rd   = r1[4:0] % 5'd12; // Few registers, so branches compare equal now and then
        rs1  = r1[9:5] % 5'd12;
        rs2  = r1[14:10] % 5'd12;
        mimm = {5'd0, r2[4:0], 2'b00};
        bofs = {7'd0, r2[3:0], 2'b00} + 13'd4; // Forward only
        jofs = {15'd0, r2[3:0], 2'b00} + 21'd4;
        case (r1[31:28])
            4'd0:  return {7'h00, rs2, rs1, 3'd0, rd, 7'h33};
            4'd1:  return {7'h20, rs2, rs1, 3'd0, rd, 7'h33};
            4'd2:  return {7'h00, rs2, rs1, 3'd7, rd, 7'h33};
            4'd3:  return {7'h00, rs2, rs1, 3'd6, rd, 7'h33};
            4'd4:  return {7'h00, rs2, rs1, 3'd4, rd, 7'h33};
            4'd5:  return {7'h00, rs2, rs1, 3'd2, rd, 7'h33};
            4'd6,
            4'd7:  return {{4{r2[7]}}, r2[7:0], rs1, 3'd0, rd, 7'h13}; // ADDI
            4'd8:  return {r2[19:0], rd, 7'h37};
            4'd9:  return {mimm, rs1, 3'd2, rd, 7'h03};
            4'd10: return {mimm[11:5], rs2, rs1, 3'd2, mimm[4:0], 7'h23};
            4'd11: return {bofs[12], bofs[10:5], rs2, rs1, 3'd0, bofs[4:1], bofs[11], 7'h63};
            4'd12: return {bofs[12], bofs[10:5], rs2, rs1, 3'd1, bofs[4:1], bofs[11], 7'h63};
            4'd13: return {jofs[20], jofs[10:1], jofs[11], jofs[19:12], rd, 7'h6f};
            4'd14: return {4'd0, r2[7:0], rs1, 3'd0, rd, 7'h67};
            default: begin
                // Custom opcode or an M-extension MUL, neither supported
                if (r1[27]) return {r2[31:7], 7'h0b};
                return {7'h01, rs2, rs1, 3'd0, rd, 7'h33};
            end
        endcase
    endfunction

    task automatic reset_state();
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < `CPU_DMEM_WORDS; i++) dmem[i] = '0;
        pc = `CPU_RESET_PC;
    endtask

    task automatic load_word(input int idx, input logic [31:0] word);
        imem[idx] = word;
    endtask

    // Works out the retire record and next pc from the current state only
    task automatic evaluate();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] imms;
        logic [31:0] immb;
        logic [31:0] immj;
        ins  = imem[(pc >> 2) % `CPU_IMEM_WORDS];
        a    = regs[ins[19:15]];
        b    = regs[ins[24:20]];
        immi = {{20{ins[31]}}, ins[31:20]};
        imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        exp_ret       = '0;
        exp_ret.valid = 1'b1;
        exp_ret.pc    = pc;
        exp_ret.instr = ins;
        next_pc       = pc + 32'd4;
        case (ins[6:0])
            7'h33: begin
                exp_ret.reg_write = 1'b1;
                case ({ins[31:25], ins[14:12]})
                    10'h000: exp_ret.wdata = a + b;
                    10'h100: exp_ret.wdata = a - b;
                    10'h007: exp_ret.wdata = a & b;
                    10'h006: exp_ret.wdata = a | b;
                    10'h004: exp_ret.wdata = a ^ b;
                    10'h002: exp_ret.wdata = {31'd0, $signed(a) < $signed(b)};
                    default: exp_ret.reg_write = 1'b0;
                endcase
            end
            7'h13: begin
                exp_ret.reg_write = (ins[14:12] == 3'd0);
                exp_ret.wdata     = exp_ret.reg_write ? a + immi : '0;
            end
            7'h37: begin
                exp_ret.reg_write = 1'b1;
                exp_ret.wdata     = {ins[31:12], 12'd0};
            end
            7'h03: begin
                exp_ret.reg_write = (ins[14:12] == 3'd2);
                exp_ret.wdata     = exp_ret.reg_write ?
                                    dmem[((a + immi) >> 2) % `CPU_DMEM_WORDS] : '0;
            end
            7'h23: begin
                if (ins[14:12] == 3'd2) begin
                    exp_ret.mem_write = 1'b1;
                    exp_ret.mem_addr  = a + imms;
                    exp_ret.mem_wdata = b;
                end
            end
            7'h63: begin
                if ((ins[14:12] == 3'd0 && a == b) || (ins[14:12] == 3'd1 && a != b))
                    next_pc = pc + immb;
            end
            7'h6f: begin
                exp_ret.reg_write = 1'b1;
                exp_ret.wdata     = pc + 32'd4;
                next_pc           = pc + immj;
            end
            7'h67: begin
                if (ins[14:12] == 3'd0) begin
                    exp_ret.reg_write = 1'b1;
                    exp_ret.wdata     = pc + 32'd4;
                    next_pc           = (a + immi) & ~32'd3;
                end
            end
            default: ; // Unknown opcode retires as a no-op
        endcase
        if (exp_ret.reg_write) exp_ret.rd = ins[11:7];
    endtask

    task automatic advance();
        if (exp_ret.reg_write && exp_ret.rd != 5'd0) regs[exp_ret.rd] = exp_ret.wdata;
        if (exp_ret.mem_write) dmem[(exp_ret.mem_addr >> 2) % `CPU_DMEM_WORDS] = exp_ret.mem_wdata;
        pc = next_pc;
    endtask

endmodule

// ==== tests/tb_cpu.sv ====
`include "cpu_defs.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int NUM_RETIRE   = 2000;
    // Program load, trailing reset, retires, plus a small allowance
    localparam int CYCLE_LIMIT  = `CPU_IMEM_WORDS + 1 + RESET_CYCLES + NUM_RETIRE + 20;

    logic                    clk;
    logic                    reset;
    logic                    prog_we;
    logic [`CPU_IMEM_AW-1:0] prog_addr;
    logic [`CPU_XLEN-1:0]    prog_data;
    retire_t                 retire;
    logic [`CPU_XLEN-1:0]    a0;
    integer                  seed;
    int                      cycle_count = 0;

    cpu_top dut_i (
        .clk_i       ( clk ),
        .reset_i     ( reset ),
        .prog_we_i   ( prog_we ),
        .prog_addr_i ( prog_addr ),
        .prog_data_i ( prog_data ),
        .retire_o    ( retire ),
        .a0_o        ( a0 )
    );

    cpu_model model_i ();

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "Cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
            $display("Finished with errors");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Every retire field and a0 against the model
    task automatic compare_retire();
        check_value("retire.valid", retire.valid, model_i.exp_ret.valid);
        check_value("retire.pc", retire.pc, model_i.exp_ret.pc);
        check_value("retire.instr", retire.instr, model_i.exp_ret.instr);
        check_value("retire.reg_write", retire.reg_write, model_i.exp_ret.reg_write);
        check_value("retire.rd", retire.rd, model_i.exp_ret.rd);
        check_value("retire.wdata", retire.wdata, model_i.exp_ret.wdata);
        check_value("retire.mem_write", retire.mem_write, model_i.exp_ret.mem_write);
        check_value("retire.mem_addr", retire.mem_addr, model_i.exp_ret.mem_addr);
        check_value("retire.mem_wdata", retire.mem_wdata, model_i.exp_ret.mem_wdata);
        check_value("a0", a0, model_i.regs[10]);
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] word;
        seed      = 32'hcee52d30;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        model_i.reset_state();

        // Program goes in while the core is held in reset
        for (int i = 0; i < `CPU_IMEM_WORDS; i++) begin
            @(posedge clk);
            #5;
            r1        = $random(seed);
            r2        = $random(seed);
            word      = model_i.make_instr(r1, r2);
            prog_we   = 1'b1;
            prog_addr = i;
            prog_data = word;
            model_i.load_word(i, word);
        end
        @(posedge clk);
        #5;
        prog_we = 1'b0;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_value("retire.valid", retire.valid, 1'b0);
            check_value("retire.reg_write", retire.reg_write, 1'b0);
            check_value("retire.mem_write", retire.mem_write, 1'b0);
            check_value("retire.pc", retire.pc, `CPU_RESET_PC);
            @(posedge clk);
            #5;
        end
        reset = 1'b0;

        // Sample mid-cycle, once the combinational retire record has settled
        for (int n = 0; n < NUM_RETIRE; n++) begin
            @(negedge clk);
            model_i.evaluate();
            compare_retire();
            model_i.advance();
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule
